/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_snes_mem_bridge
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_tests.svh */
// Bus helpers, sampled on the falling edge

task automatic rom_access(input snes_mem_pkg::rom_addr_t addr, input logic word_mode,
                          output snes_mem_pkg::word_t got);
    @(posedge mclk);
    rom_addr   <= addr;
    rom_word   <= word_mode;
    rom_ce_n   <= 1'b0;
    sysclkf_ce <= 1'b1;
    @(posedge mclk);                // Phase strobe taken here
    sysclkf_ce <= 1'b0;
    repeat (3) @(posedge mclk);
    @(negedge mclk);
    got = rom_q;
    @(posedge mclk);
    rom_ce_n <= 1'b1;
endtask

task automatic wram_write(input snes_mem_pkg::wram_addr_t addr, input snes_mem_pkg::byte_t data);
    @(posedge mclk);
    wram_addr  <= addr;
    wram_d     <= data;
    wram_ce_n  <= 1'b0;
    wram_we_n  <= 1'b0;
    sysclkr_ce <= 1'b1;
    @(posedge mclk);
    sysclkr_ce <= 1'b0;
    repeat (3) @(posedge mclk);     // Store written by now
    wram_ce_n <= 1'b1;
    wram_we_n <= 1'b1;
endtask

task automatic wram_read(input snes_mem_pkg::wram_addr_t addr, output snes_mem_pkg::byte_t got);
    @(posedge mclk);
    wram_addr  <= addr;
    wram_ce_n  <= 1'b0;
    wram_rd_n  <= 1'b0;
    sysclkf_ce <= 1'b1;
    @(posedge mclk);
    sysclkf_ce <= 1'b0;
    repeat (3) @(posedge mclk);
    @(negedge mclk);
    got = wram_q;
    @(posedge mclk);
    wram_ce_n <= 1'b1;
    wram_rd_n <= 1'b1;
endtask

task automatic reset_state_test();
    start_test("reset_state");
    repeat (2) @(posedge mclk);
    @(negedge mclk);
    check_value("loaded", 32'd0, 32'(loaded));
    check_value("cpu_enable", 32'd0, 32'(cpu_enable));
    check_value("vram1_rd", 32'd0, 32'(vram1_rd));
    check_value("vram2_rd", 32'd0, 32'(vram2_rd));
    check_value("rom_q", 32'd0, 32'(rom_q));
    check_value("wram_q", 32'd0, 32'(wram_q));
    finish_test();
endtask

task automatic load_test();
    snes_mem_pkg::byte_t b;
    int waits;
    start_test("load");
    @(posedge mclk);
    loading <= 1'b1;                // Address clears on this edge
    @(negedge mclk);
    check_value("cpu_resetn at load start", 32'd0, 32'(cpu_resetn));
    for (int i = 0; i < LOAD_BYTES; i++) begin
        @(posedge mclk);
        b = lfsr_byte();
        model_mem[model_index(23'(i))] = b;
        loader_valid <= 1'b1;
        loader_data  <= b;
    end
    @(posedge mclk);
    loader_valid <= 1'b0;
    repeat (3) @(posedge mclk);     // Last byte reaches the store
    @(negedge mclk);
    check_value("cpu_resetn at load end", 32'd0, 32'(cpu_resetn));
    @(posedge mclk);
    loading <= 1'b0;
    @(posedge mclk);
    @(negedge mclk);
    check_value("loaded", 32'd1, 32'(loaded));
    waits = 0;
    while (!cpu_enable && waits < 2) begin
        @(negedge mclk);
        waits++;
    end
    check_value("cpu_enable after load", 32'd1, 32'(cpu_enable));
    finish_test();
endtask

task automatic rom_read_test();
    snes_mem_pkg::word_t got;
    snes_mem_pkg::word_t want;
    start_test("rom_read");
    for (int i = 0; i < LOAD_BYTES; i += 2) begin
        rom_access(24'(i), 1'b1, got);
        want = model_word(23'(i));
        check_value($sformatf("word at %0d", i), 32'(want), 32'(got));
    end
    // Odd byte read moves the high byte down
    for (int i = 1; i < LOAD_BYTES; i += 2) begin
        rom_access(24'(i), 1'b0, got);
        want = model_word(23'(i));
        want = {want[7:0], want[15:8]};
        check_value($sformatf("swapped at %0d", i), 32'(want), 32'(got));
    end
    finish_test();
endtask

task automatic wram_test();
    snes_mem_pkg::wram_addr_t wa;
    snes_mem_pkg::byte_t      b;
    snes_mem_pkg::byte_t      got;
    start_test("wram");
    for (int i = 0; i < WRAM_BYTES; i++) begin
        wa = WRAM_TEST_BASE + 17'(i);
        b  = lfsr_byte();
        model_mem[model_index({snes_mem_pkg::WRAM_BASE, wa})] = b;
        wram_write(wa, b);
    end
    for (int i = 0; i < WRAM_BYTES; i++) begin
        wa = WRAM_TEST_BASE + 17'(i);
        wram_read(wa, got);
        b = model_mem[model_index({snes_mem_pkg::WRAM_BASE, wa})];
        check_value($sformatf("byte at %h", wa), 32'(b), 32'(got));
    end
    finish_test();
endtask

task automatic pause_test();
    snes_mem_pkg::word_t got;
    int waits;
    start_test("back_pressure");
    rom_access(24'd4, 1'b1, got);
    check_value("read before pause", 32'(model_word(23'd4)), 32'(got));
    @(posedge mclk);
    frame_pause <= 1'b1;
    waits = 0;
    @(negedge mclk);
    while (cpu_enable && waits < 4) begin
        @(negedge mclk);
        waits++;
    end
    check_value("cpu_enable drops", 32'd0, 32'(cpu_enable));
    rom_access(24'd10, 1'b1, got);  // Phase strobe is masked
    check_value("rom_q held", 32'(model_word(23'd4)), 32'(got));
    check_value("cpu_enable held low", 32'd0, 32'(cpu_enable));
    @(posedge mclk);
    frame_pause <= 1'b0;
    waits = 0;
    @(negedge mclk);
    while (!cpu_enable && waits < 4) begin
        @(negedge mclk);
        waits++;
    end
    check_value("cpu_enable back", 32'd1, 32'(cpu_enable));
    rom_access(24'd10, 1'b1, got);
    check_value("read after release", 32'(model_word(23'd10)), 32'(got));
    finish_test();
endtask

task automatic vram_filter_test();
    int pulses;
    start_test("vram_filter");
    pulses = 0;
    @(posedge mclk);
    vram_oe_n  <= 1'b0;
    vram1_addr <= 16'h0120;
    vram2_addr <= 16'h0120;
    repeat (3) begin
        @(negedge mclk);
        if (vram1_rd)
            pulses++;
        @(posedge mclk);
    end
    vram_oe_n <= 1'b1;
    check_value("steady address pulses", 32'd1, 32'(pulses));
    // Differing addresses, port 2 waits one cycle
    @(posedge mclk);
    vram_oe_n  <= 1'b0;
    vram1_addr <= 16'h0200;
    vram2_addr <= 16'h0344;
    @(negedge mclk);
    check_value("split vram1_rd", 32'd1, 32'(vram1_rd));
    check_value("split vram2_rd first", 32'd0, 32'(vram2_rd));
    @(posedge mclk);
    @(negedge mclk);
    check_value("split vram1_rd next", 32'd0, 32'(vram1_rd));
    check_value("deferred vram2_rd", 32'd1, 32'(vram2_rd));
    @(posedge mclk);
    vram_oe_n <= 1'b1;
    @(posedge mclk);
    vram_oe_n  <= 1'b0;
    vram1_addr <= 16'h0410;
    vram2_addr <= 16'h0410;
    @(negedge mclk);
    check_value("equal vram1_rd", 32'd1, 32'(vram1_rd));
    check_value("equal vram2_rd", 32'd1, 32'(vram2_rd));
    @(posedge mclk);
    @(negedge mclk);
    check_value("no extra vram2_rd", 32'd0, 32'(vram2_rd));
    @(posedge mclk);
    vram_oe_n <= 1'b1;
    finish_test();
endtask

/* bench/tb_snes_mem_bridge.sv */
`timescale 1ns/1ps

module tb_snes_mem_bridge;

    localparam int STORE_AW    = 10;
    localparam int MODEL_BYTES = 2 ** (STORE_AW + 1);
    localparam int LOAD_BYTES  = 32;
    localparam int WRAM_BYTES  = 8;
    localparam snes_mem_pkg::wram_addr_t WRAM_TEST_BASE = 17'h00400;   // Clear of the image

    // Cycle budgets, reset first, then the tests in run order
    localparam int RESET_CYCLES   = 8;
    localparam int TEST_CYCLES    = RESET_CYCLES + 10 + (LOAD_BYTES + 12) + 7 * LOAD_BYTES
                                    + 13 * WRAM_BYTES + 40 + 20;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                     mclk;
    logic                     resetn;
    logic                     loading;
    logic                     loader_valid;
    snes_mem_pkg::byte_t      loader_data;
    logic                     mem_busy;
    logic                     frame_pause;
    logic                     sysclkf_ce;
    logic                     sysclkr_ce;
    snes_mem_pkg::rom_addr_t  rom_addr;
    logic                     rom_ce_n;
    logic                     rom_word;
    snes_mem_pkg::word_t      rom_q;
    snes_mem_pkg::wram_addr_t wram_addr;
    logic                     wram_ce_n;
    logic                     wram_rd_n;
    logic                     wram_we_n;
    snes_mem_pkg::byte_t      wram_d;
    snes_mem_pkg::byte_t      wram_q;
    logic                     vram_oe_n;
    snes_mem_pkg::vram_addr_t vram1_addr;
    snes_mem_pkg::vram_addr_t vram2_addr;
    logic                     vram1_rd;
    logic                     vram2_rd;
    logic                     loaded;
    logic                     cpu_enable;
    logic                     cpu_resetn;

    snes_mem_pkg::byte_t model_mem [MODEL_BYTES];   // Byte view of the word store
    logic [31:0]         lfsr_state;
    int                  cycle_count = 0;
    int                  test_errors;
    int                  error_count = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    string               test_name;

    snes_mem_bridge #(.STORE_AW(STORE_AW)) dut_i (
        .mclk(mclk), .resetn(resetn), .loading(loading), .loader_valid(loader_valid),
        .loader_data(loader_data), .mem_busy(mem_busy), .frame_pause(frame_pause),
        .sysclkf_ce(sysclkf_ce), .sysclkr_ce(sysclkr_ce),
        .rom_addr(rom_addr), .rom_ce_n(rom_ce_n), .rom_word(rom_word), .rom_q(rom_q),
        .wram_addr(wram_addr), .wram_ce_n(wram_ce_n), .wram_rd_n(wram_rd_n),
        .wram_we_n(wram_we_n), .wram_d(wram_d), .wram_q(wram_q),
        .vram_oe_n(vram_oe_n), .vram1_addr(vram1_addr), .vram2_addr(vram2_addr),
        .vram1_rd(vram1_rd), .vram2_rd(vram2_rd),
        .loaded(loaded), .cpu_enable(cpu_enable), .cpu_resetn(cpu_resetn)
    );

    always #2 mclk = ~mclk;

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'hb4bc_d35c;
        return out;
    endfunction

    function automatic snes_mem_pkg::byte_t lfsr_byte();
        snes_mem_pkg::byte_t b;
        for (int i = 0; i < 8; i++)
            b[i] = lfsr_bit();
        return b;
    endfunction

    // Higher address bits alias onto the small store
    function automatic int model_index(input snes_mem_pkg::mem_addr_t addr);
        return int'(addr[STORE_AW:0]);
    endfunction

    function automatic snes_mem_pkg::word_t model_word(input snes_mem_pkg::mem_addr_t addr);
        snes_mem_pkg::mem_addr_t even;
        even = {addr[22:1], 1'b0};
        return {model_mem[model_index(even | 23'd1)], model_mem[model_index(even)]};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s passed", test_name);
        end else begin
            tests_failed++;
            error_count += test_errors;
            $display("Test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    `include "tb_tests.svh"

    // Run limit
    always @(posedge mclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles, a test got stuck", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        mclk         = 1'b0;
        lfsr_state   = 32'hd4bb;
        resetn       <= 1'b0;
        loading      <= 1'b0;
        loader_valid <= 1'b0;
        loader_data  <= '0;
        mem_busy     <= 1'b0;
        frame_pause  <= 1'b0;
        sysclkf_ce   <= 1'b0;
        sysclkr_ce   <= 1'b0;
        rom_addr     <= '0;
        rom_ce_n     <= 1'b1;
        rom_word     <= 1'b1;
        wram_addr    <= '0;
        wram_ce_n    <= 1'b1;
        wram_rd_n    <= 1'b1;
        wram_we_n    <= 1'b1;
        wram_d       <= '0;
        vram_oe_n    <= 1'b1;
        vram1_addr   <= '0;
        vram2_addr   <= '0;
        repeat (RESET_CYCLES) @(posedge mclk);
        resetn <= 1'b1;

        reset_state_test();
        load_test();
        rom_read_test();
        wram_test();
        pause_test();
        vram_filter_test();

        $display("Summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* logic/load_control.sv */
`timescale 1ns/1ps

module load_control (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    loading,
    input  logic                    loader_valid,
    input  logic                    mem_busy,
    input  logic                    frame_pause,
    output snes_mem_pkg::rom_addr_t loader_addr,
    output logic                    loaded,
    output logic                    cpu_enable,
    output logic                    cpu_resetn
);

    logic loading_r;                // Loading level from last cycle
    logic load_start;
    logic load_end;

    assign load_start = loading & ~loading_r;
    assign load_end   = ~loading & loading_r;

    // Image address counter and loaded flag
    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r   <= 1'b0;
            loaded      <= 1'b0;
            loader_addr <= '0;
        end else begin
            loading_r <= loading;
            if (loading && loader_valid)
                loader_addr <= loader_addr + 24'd1;   // Byte already used this cycle
            // A new image always starts at address 0
            if (load_start) begin
                loader_addr <= '0;
                loaded      <= 1'b0;
            end
            if (load_end)
                loaded <= 1'b1;
        end
    end

    // Core runs only with a loaded image and the memory free
    always_ff @(posedge mclk) begin
        if (!resetn)
            cpu_enable <= 1'b0;
        else
            cpu_enable <= loaded & ~mem_busy & ~frame_pause;
    end

    assign cpu_resetn = resetn & ~loading;   // Core held in reset while loading

    // Counter is frozen outside of loading
    addr_frozen_a: assert property (
        @(posedge mclk) disable iff (!resetn)
        $past(resetn) && !$past(loading) |-> $stable(loader_addr)
    );

endmodule

/* logic/mem_request_arbiter.sv */
`timescale 1ns/1ps

module mem_request_arbiter (
    input  logic                     mclk,
    input  logic                     resetn,
    input  logic                     cpu_enable,
    input  logic                     sysclkf_ce,
    input  logic                     sysclkr_ce,
    input  logic                     loading,
    input  logic                     loader_valid,
    input  snes_mem_pkg::byte_t      loader_data,
    input  snes_mem_pkg::rom_addr_t  loader_addr,
    input  snes_mem_pkg::rom_addr_t  rom_addr,
    input  logic                     rom_ce_n,
    input  snes_mem_pkg::wram_addr_t wram_addr,
    input  logic                     wram_ce_n,
    input  logic                     wram_rd_n,
    input  logic                     wram_we_n,
    input  snes_mem_pkg::byte_t      wram_d,
    output logic                     mem_rd,
    output logic                     mem_wr,
    output snes_mem_pkg::mem_addr_t  mem_addr,
    output snes_mem_pkg::word_t      mem_din,
    output snes_mem_pkg::lanes_t     mem_lanes,
    output logic                     mem_port
);

    logic f2;                       // Delayed fall phase
    logic r2;                       // Delayed rise phase
    logic wram_rd;
    logic wram_wr;

    logic                    req_rd;
    logic                    req_wr;
    snes_mem_pkg::mem_addr_t req_addr;
    snes_mem_pkg::word_t     req_din;
    snes_mem_pkg::lanes_t    req_lanes;
    logic                    req_port;

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;

    // Phase strobes only count while the core runs
    always_ff @(posedge mclk) begin
        if (!resetn) begin
            f2 <= 1'b0;
            r2 <= 1'b0;
        end else begin
            f2 <= sysclkf_ce & cpu_enable;
            r2 <= sysclkr_ce & cpu_enable;
        end
    end

    // Loader, then work RAM, then ROM
    always_comb begin
        req_rd    = 1'b0;
        req_wr    = 1'b0;
        req_addr  = '0;
        req_din   = '0;
        req_lanes = '0;
        req_port  = 1'b0;
        if (loading && loader_valid) begin
            req_wr    = 1'b1;
            req_addr  = loader_addr[22:0];
            req_din   = {loader_data, loader_data};
            req_lanes = {loader_addr[0], ~loader_addr[0]};
        end else if (wram_rd || wram_wr) begin
            // Work RAM blocks ROM even outside its phase
            req_addr  = {snes_mem_pkg::WRAM_BASE, wram_addr};
            req_din   = {wram_d, wram_d};
            req_lanes = {wram_addr[0], ~wram_addr[0]};
            req_port  = 1'b1;
            req_rd    = wram_rd & f2;
            req_wr    = wram_wr & r2;
        end else if (!rom_ce_n && f2) begin
            req_rd    = 1'b1;
            req_addr  = rom_addr[22:0];
            req_lanes = 2'b11;   // Whole word
        end
    end

    // Registered request stage
    always_ff @(posedge mclk) begin
        if (!resetn) begin
            mem_rd <= 1'b0;
            mem_wr <= 1'b0;
        end else begin
            mem_rd <= req_rd;
            mem_wr <= req_wr;
        end
    end

    always_ff @(posedge mclk) begin
        mem_addr  <= req_addr;
        mem_din   <= req_din;
        mem_lanes <= req_lanes;
        mem_port  <= req_port;
    end

    one_access_a: assert property (
        @(posedge mclk) disable iff (!resetn)
        !(mem_rd && mem_wr)
    );

endmodule

/* logic/snes_mem_bridge.sv */
`timescale 1ns/1ps

module snes_mem_bridge #(
    parameter int STORE_AW = 10
) (
    input  logic                     mclk,
    input  logic                     resetn,
    input  logic                     loading,
    input  logic                     loader_valid,
    input  snes_mem_pkg::byte_t      loader_data,
    input  logic                     mem_busy,
    input  logic                     frame_pause,
    input  logic                     sysclkf_ce,
    input  logic                     sysclkr_ce,
    input  snes_mem_pkg::rom_addr_t  rom_addr,
    input  logic                     rom_ce_n,
    input  logic                     rom_word,
    output snes_mem_pkg::word_t      rom_q,
    input  snes_mem_pkg::wram_addr_t wram_addr,
    input  logic                     wram_ce_n,
    input  logic                     wram_rd_n,
    input  logic                     wram_we_n,
    input  snes_mem_pkg::byte_t      wram_d,
    output snes_mem_pkg::byte_t      wram_q,
    input  logic                     vram_oe_n,
    input  snes_mem_pkg::vram_addr_t vram1_addr,
    input  snes_mem_pkg::vram_addr_t vram2_addr,
    output logic                     vram1_rd,
    output logic                     vram2_rd,
    output logic                     loaded,
    output logic                     cpu_enable,
    output logic                     cpu_resetn
);

    snes_mem_pkg::rom_addr_t loader_addr;
    logic                    mem_rd;
    logic                    mem_wr;
    snes_mem_pkg::mem_addr_t mem_addr;
    snes_mem_pkg::word_t     mem_din;
    snes_mem_pkg::lanes_t    mem_lanes;
    logic                    mem_port;

    load_control load_i (
        .mclk(mclk), .resetn(resetn), .loading(loading), .loader_valid(loader_valid),
        .mem_busy(mem_busy), .frame_pause(frame_pause), .loader_addr(loader_addr),
        .loaded(loaded), .cpu_enable(cpu_enable), .cpu_resetn(cpu_resetn)
    );

    mem_request_arbiter arb_i (
        .mclk(mclk), .resetn(resetn), .cpu_enable(cpu_enable),
        .sysclkf_ce(sysclkf_ce), .sysclkr_ce(sysclkr_ce),
        .loading(loading), .loader_valid(loader_valid), .loader_data(loader_data),
        .loader_addr(loader_addr), .rom_addr(rom_addr), .rom_ce_n(rom_ce_n),
        .wram_addr(wram_addr), .wram_ce_n(wram_ce_n), .wram_rd_n(wram_rd_n),
        .wram_we_n(wram_we_n), .wram_d(wram_d),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_din(mem_din),
        .mem_lanes(mem_lanes), .mem_port(mem_port)
    );

    word_store #(.STORE_AW(STORE_AW)) store_i (
        .mclk(mclk), .resetn(resetn), .mem_rd(mem_rd), .mem_wr(mem_wr),
        .mem_addr(mem_addr), .mem_din(mem_din), .mem_lanes(mem_lanes),
        .mem_port(mem_port), .rom_addr(rom_addr), .rom_word(rom_word),
        .wram_addr(wram_addr), .rom_q(rom_q), .wram_q(wram_q)
    );

    vram_read_filter vram_i (
        .mclk(mclk), .resetn(resetn), .vram_oe_n(vram_oe_n),
        .vram1_addr(vram1_addr), .vram2_addr(vram2_addr),
        .vram1_rd(vram1_rd), .vram2_rd(vram2_rd)
    );

endmodule

/* logic/snes_mem_pkg.sv */
package snes_mem_pkg;

    // Data widths
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // Byte address into the shared word memory
    typedef logic [22:0] mem_addr_t;

    // Core ROM bus address, also used as the loader address
    typedef logic [23:0] rom_addr_t;

    // Work RAM, 128 KB of byte addresses
    typedef logic [16:0] wram_addr_t;

    // Video RAM address, only bits 14:0 reach the memory
    typedef logic [15:0] vram_addr_t;

    // Byte lane enables, bit 0 is the even (low) byte
    typedef logic [1:0]  lanes_t;

    // Upper address bits that place work RAM at the top of the memory
    localparam logic [5:0] WRAM_BASE = 6'b111111;

endpackage

/* logic/vram_read_filter.sv */
`timescale 1ns/1ps

module vram_read_filter (
    input  logic                     mclk,
    input  logic                     resetn,
    input  logic                     vram_oe_n,
    input  snes_mem_pkg::vram_addr_t vram1_addr,
    input  snes_mem_pkg::vram_addr_t vram2_addr,
    output logic                     vram1_rd,
    output logic                     vram2_rd
);

    logic        oe_n_old;
    logic [14:0] addr1_old;
    logic [14:0] addr2_old;
    logic        new1;
    logic        new2;
    logic        defer;              // Port 2 must wait a cycle
    logic        defer_r;

    // Only a fresh output enable or a changed address is a new read
    assign new1 = ~vram_oe_n & (oe_n_old | (addr1_old != vram1_addr[14:0]));
    assign new2 = ~vram_oe_n & (oe_n_old | (addr2_old != vram2_addr[14:0]));

    // Both ports at different words cannot be served together
    assign defer = new1 & new2 & (vram1_addr != vram2_addr);

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            oe_n_old <= 1'b1;
            defer_r  <= 1'b0;
        end else begin
            oe_n_old <= vram_oe_n;
            defer_r  <= defer;
        end
    end

    // Last addresses seen on each port
    always_ff @(posedge mclk) begin
        addr1_old <= vram1_addr[14:0];
        addr2_old <= vram2_addr[14:0];
    end

    assign vram1_rd = new1;
    assign vram2_rd = (new2 & ~defer) | defer_r;

    // A deferred read always comes from an enabled cycle
    defer_from_read_a: assert property (
        @(posedge mclk) disable iff (!resetn)
        defer_r |-> !$past(vram_oe_n)
    );

endmodule

/* logic/word_store.sv */
`timescale 1ns/1ps

module word_store #(
    parameter int STORE_AW = 10
) (
    input  logic                     mclk,
    input  logic                     resetn,
    input  logic                     mem_rd,
    input  logic                     mem_wr,
    input  snes_mem_pkg::mem_addr_t  mem_addr,
    input  snes_mem_pkg::word_t      mem_din,
    input  snes_mem_pkg::lanes_t     mem_lanes,
    input  logic                     mem_port,
    input  snes_mem_pkg::rom_addr_t  rom_addr,
    input  logic                     rom_word,
    input  snes_mem_pkg::wram_addr_t wram_addr,
    output snes_mem_pkg::word_t      rom_q,
    output snes_mem_pkg::byte_t      wram_q
);

    localparam int DEPTH = 2 ** STORE_AW;

    snes_mem_pkg::word_t mem [DEPTH];

    logic [STORE_AW-1:0] word_idx;
    snes_mem_pkg::word_t port0_q;    // ROM side latch
    snes_mem_pkg::word_t port1_q;    // Work RAM side latch

    // Upper address bits fold onto the small store
    assign word_idx = mem_addr[STORE_AW:1];

    // Lane masked write
    always_ff @(posedge mclk) begin
        if (mem_wr) begin
            if (mem_lanes[0])
                mem[word_idx][7:0] <= mem_din[7:0];
            if (mem_lanes[1])
                mem[word_idx][15:8] <= mem_din[15:8];
        end
    end

    // Each port keeps its last read word
    always_ff @(posedge mclk) begin
        if (!resetn) begin
            port0_q <= '0;
            port1_q <= '0;
        end else if (mem_rd) begin
            if (mem_port)
                port1_q <= mem[word_idx];
            else
                port0_q <= mem[word_idx];
        end
    end

    // Byte reads at odd ROM addresses want the high byte in the low lane
    assign rom_q = (rom_word || !rom_addr[0]) ? port0_q : {port0_q[7:0], port0_q[15:8]};

    assign wram_q = wram_addr[0] ? port1_q[15:8] : port1_q[7:0];

endmodule

/* project.f */
+incdir+bench
logic/snes_mem_pkg.sv
logic/load_control.sv
logic/vram_read_filter.sv
logic/mem_request_arbiter.sv
logic/word_store.sv
logic/snes_mem_bridge.sv
bench/tb_snes_mem_bridge.sv
